// File: verilog.f
source/vid_timing_pkg.sv
source/gap_timing_if.sv
source/timing_cfg_regs.sv
source/sync_recover.sv
source/video_rx_top.sv
dv/video_rx_checker.sv
dv/video_rx_assert.sv
dv/tb_video_rx.sv

// File: Makefile
# Verilator build for the video timing recovery testbench

VERILATOR ?= verilator
TOP       ?= tb_video_rx
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Something failed" $(LOG); then \
		echo "simulation FAILED"; exit 1; \
	fi
	@if ! grep -q "Everything OK" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/tb_video_rx.sv
`timescale 1ns/1ns

module tb_video_rx
  import vid_timing_pkg::*;
();

  localparam int PIX_W = 24;
  localparam int N_FRAMES = 10;
  localparam int FRAME_MAX = 1000;
  localparam int N_REG_OPS = 60;
  localparam int WATCHDOG_CYCLES = N_FRAMES * FRAME_MAX + N_REG_OPS * 40 + 200;

  logic clk = 1'b0;
  logic reset = 1'b1;
  logic pix_valid = 1'b0;
  logic [PIX_W-1:0] pix_data = '0;
  logic [PIX_W-1:0] out_data;
  logic de, hsync, vsync;
  pix_cnt_t hcount;
  line_cnt_t vcount;
  logic cfg_req = 1'b0;
  logic cfg_we = 1'b0;
  reg_addr_t cfg_addr = '0;
  reg_data_t cfg_wdata = '0;
  logic cfg_ack;
  reg_data_t cfg_rdata;

  int cyc = 0;
  // host side of the register port, applied at the next edge
  logic host_req = 1'b0;
  logic host_we = 1'b0;
  reg_addr_t host_addr = '0;
  reg_data_t host_wdata = '0;
  logic last_req = 1'b0;

  // reference model state during the current input cycle
  int m_idle = 0;
  bit m_line_armed = 0;
  bit m_frame_armed = 0;
  int m_pix = 0;
  int m_line = 0;
  int m_hs = 0;
  bit m_vs = 0;
  int m_line_len = 0;
  int m_frame_lines = 0;
  int m_hgap = 16;
  int m_vgap = 200;
  int m_hslen = 8;
  bit m_pol = 0;

  always #50 clk = ~clk;

  video_rx_top #(.PIX_W(PIX_W)) u_dut (
    .clk (clk), .reset (reset),
    .pix_valid (pix_valid), .pix_data (pix_data),
    .out_data (out_data), .de (de), .hsync (hsync), .vsync (vsync),
    .hcount (hcount), .vcount (vcount),
    .cfg_req (cfg_req), .cfg_we (cfg_we), .cfg_addr (cfg_addr),
    .cfg_wdata (cfg_wdata), .cfg_ack (cfg_ack), .cfg_rdata (cfg_rdata)
  );

  video_rx_checker #(.PIX_W(PIX_W)) u_chk (
    .clk (clk), .cyc (cyc),
    .out_data (out_data), .de (de), .hsync (hsync), .vsync (vsync),
    .hcount (hcount), .vcount (vcount),
    .cfg_ack (cfg_ack), .cfg_we (cfg_we), .cfg_rdata (cfg_rdata)
  );

  // stream rules applied to one input cycle
  task automatic model_step(input bit v, input logic [PIX_W-1:0] d, input bit acc);
    int idle_run;
    bit line_evt;
    bit frame_evt;
    int pix_shown;
    int line_shown;
    reg_data_t rd;
    if (v) idle_run = 0;
    else if (m_idle == 65535) idle_run = m_idle;
    else idle_run = m_idle + 1;
    line_evt  = !v && idle_run == m_hgap && m_line_armed;
    frame_evt = !v && idle_run == m_vgap && m_frame_armed;
    if (acc && !host_we) begin
      case (host_addr)
        3'd0: rd = reg_data_t'(m_hgap);
        3'd1: rd = reg_data_t'(m_vgap);
        3'd2: rd = reg_data_t'(m_hslen);
        3'd3: rd = reg_data_t'(m_pol);
        3'd4: rd = reg_data_t'(m_line_len);
        3'd5: rd = reg_data_t'(m_frame_lines);
        default: rd = '0;
      endcase
      u_chk.push_read(rd);
    end
    // hcount and vcount shown before this cycle's update
    pix_shown = m_pix;
    line_shown = m_line;
    if (line_evt && m_pix != 0) m_line_len = m_pix;
    if (frame_evt) m_frame_lines = m_line;
    if (line_evt) m_pix = 0;
    else if (v) m_pix++;
    if (frame_evt) m_line = 0;
    else if (line_evt) m_line++;
    if (line_evt) m_hs = m_hslen;
    else if (m_hs != 0) m_hs--;
    if (frame_evt) m_vs = 1;
    else if (v) m_vs = 0;
    if (v) m_line_armed = 1;
    else if (line_evt) m_line_armed = 0;
    if (line_evt) m_frame_armed = 1;
    else if (frame_evt || v) m_frame_armed = 0;
    m_idle = idle_run;
    if (acc && host_we) begin
      case (host_addr)
        3'd0: m_hgap = int'(host_wdata);
        3'd1: m_vgap = int'(host_wdata);
        3'd2: m_hslen = int'(host_wdata[7:0]);
        3'd3: m_pol = host_wdata[0];
        default: ;
      endcase
    end
    // sync bits follow the updated sync state and the new polarity
    u_chk.push_exp(cyc + 2, {d, v, ((m_hs != 0) ^ m_pol), (m_vs ^ m_pol),
                             pix_cnt_t'(pix_shown), line_cnt_t'(line_shown)});
  endtask

  task automatic drive_cycle(input bit v, input logic [PIX_W-1:0] d);
    @(posedge clk);
    cyc++;
    pix_valid <= v;
    pix_data  <= d;
    cfg_req   <= host_req;
    cfg_we    <= host_we;
    cfg_addr  <= host_addr;
    cfg_wdata <= host_wdata;
    model_step(v, d, host_req && !last_req);
    last_req = host_req;
  endtask

  task automatic reg_access(input bit we, input reg_addr_t addr, input reg_data_t wdata);
    int waited;
    host_req = 1'b1;
    host_we = we;
    host_addr = addr;
    host_wdata = wdata;
    drive_cycle(1'b0, PIX_W'($urandom));
    waited = 0;
    forever begin
      @(negedge clk);
      if (cfg_ack || waited == 16) break;
      drive_cycle(1'b0, PIX_W'($urandom));
      waited++;
    end
    if (!cfg_ack) u_chk.note_fail("cfg_ack never rose");
    host_req = 1'b0;
    drive_cycle(1'b0, PIX_W'($urandom));
    waited = 0;
    forever begin
      @(negedge clk);
      if (!cfg_ack || waited == 16) break;
      drive_cycle(1'b0, PIX_W'($urandom));
      waited++;
    end
    if (cfg_ack) u_chk.note_fail("cfg_ack never fell after req dropped");
  endtask

  task automatic send_frame();
    int nl;
    int len;
    int gap;
    nl = $urandom_range(6, 2);
    for (int l = 0; l < nl; l++) begin
      len = $urandom_range(48, 1);
      repeat (len) drive_cycle(1'b1, PIX_W'($urandom));
      if (l < nl - 1) gap = $urandom_range(m_vgap - 1, m_hgap);
      else gap = $urandom_range(m_vgap + 10, m_vgap);
      repeat (gap) drive_cycle(1'b0, PIX_W'($urandom));
    end
  endtask

  task automatic set_timing(input int hgap, input int vgap, input int hslen);
    reg_access(1'b1, ADDR_HGAP_MIN, reg_data_t'(hgap));
    reg_access(1'b1, ADDR_VGAP_MIN, reg_data_t'(vgap));
    reg_access(1'b1, ADDR_HSYNC_LEN, reg_data_t'(hslen));
  endtask

  // last stimulus cycle is compared two negedges before the closing edge
  task automatic close_test();
    repeat (3) drive_cycle(1'b0, '0);
    u_chk.end_test();
  endtask

  initial begin
    int hgap;
    void'($urandom(12137));
    repeat (16) @(posedge clk);
    reset <= 1'b0;
    // outputs of the two cycles still flushing reset values
    u_chk.push_exp(0, '0);
    u_chk.push_exp(1, '0);
    model_step(1'b0, '0, 1'b0);

    u_chk.start_test("reset_state");
    for (int a = 0; a < 4; a++) reg_access(1'b0, reg_addr_t'(a), '0);
    close_test();

    u_chk.start_test("reg_access");
    repeat (24) reg_access(1'($urandom), reg_addr_t'($urandom), reg_data_t'($urandom));
    close_test();

    u_chk.start_test("pixel_path");
    set_timing(12, 60, 8);
    reg_access(1'b1, ADDR_POLARITY, '0);
    repeat (3) send_frame();
    close_test();

    u_chk.start_test("sync_pulses");
    repeat (3) begin
      hgap = $urandom_range(20, 4);
      set_timing(hgap, hgap + $urandom_range(60, 30), $urandom_range(20, 1));
      send_frame();
    end
    close_test();

    u_chk.start_test("polarity");
    reg_access(1'b1, ADDR_POLARITY, 16'hfffd);
    repeat (2) send_frame();
    reg_access(1'b1, ADDR_POLARITY, '0);
    close_test();

    u_chk.start_test("status_regs");
    repeat (2) begin
      send_frame();
      reg_access(1'b0, ADDR_LINE_LEN, '0);
      reg_access(1'b0, ADDR_FRAME_LINES, '0);
    end
    close_test();

    $display("tests passed %0d, failed %0d, errors %0d",
             u_chk.n_pass, u_chk.n_fail, u_chk.errors);
    if (u_chk.n_fail == 0 && u_chk.errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // watchdog sized from the planned frames and register accesses
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("run timed out after %0d cycles", WATCHDOG_CYCLES);
    $display("Something failed");
    $finish;
  end

endmodule

// File: dv/video_rx_assert.sv
`timescale 1ns/1ns

module video_rx_assert (
  input logic clk,
  input logic reset,
  input logic req,
  input logic ack,
  input logic de,
  input logic vsync,
  input logic polarity
);

  // ack only answers a request
  ack_needs_req: assert property (@(posedge clk) disable iff (reset)
    $rose(ack) |-> $past(req))
    else $error("cfg_ack rose without cfg_req");

  // four-phase, ack stays up until req is dropped
  ack_holds: assert property (@(posedge clk) disable iff (reset)
    $fell(ack) |-> !$past(req))
    else $error("cfg_ack fell while cfg_req was high");

  // output polarity lags the register by one cycle
  de_outside_vsync: assert property (@(posedge clk) disable iff (reset)
    de |-> (vsync == $past(polarity)))
    else $error("de high while vsync active");

endmodule

bind timing_cfg_regs video_rx_assert u_hs_assert (
  .clk      (clk),
  .reset    (reset),
  .req      (cfg_req),
  .ack      (cfg_ack),
  .de       (1'b0),
  .vsync    (1'b0),
  .polarity (1'b0)
);

bind sync_recover video_rx_assert u_sync_assert (
  .clk      (clk),
  .reset    (reset),
  .req      (1'b0),
  .ack      (1'b0),
  .de       (de),
  .vsync    (vsync),
  .polarity (tim.polarity)
);

// File: dv/video_rx_checker.sv
`timescale 1ns/1ns

module video_rx_checker
  import vid_timing_pkg::*;
#(
  parameter int PIX_W = 24
) (
  input logic             clk,
  input int               cyc,
  input logic [PIX_W-1:0] out_data,
  input logic             de,
  input logic             hsync,
  input logic             vsync,
  input pix_cnt_t         hcount,
  input line_cnt_t        vcount,
  input logic             cfg_ack,
  input logic             cfg_we,
  input reg_data_t        cfg_rdata
);

  typedef struct packed {
    logic [PIX_W-1:0] data;
    logic             de;
    logic             hs;
    logic             vs;
    pix_cnt_t         hc;
    line_cnt_t        vc;
  } exp_t;

  exp_t      exp_q[$];
  int        due_q[$];
  reg_data_t rd_q[$];
  exp_t      cur;
  logic      ack_seen = 1'b0;
  string     cur_test = "none";
  int        test_errs = 0;
  int        errors = 0;
  int        n_pass = 0;
  int        n_fail = 0;

  task automatic start_test(input string name);
    cur_test  = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    if (test_errs == 0) begin
      n_pass++;
      $display("test %s passed", cur_test);
    end else begin
      n_fail++;
      $display("test %s failed with %0d errors", cur_test, test_errs);
    end
  endtask

  task automatic push_exp(input int due, input exp_t e);
    due_q.push_back(due);
    exp_q.push_back(e);
  endtask

  task automatic push_read(input reg_data_t val);
    rd_q.push_back(val);
  endtask

  task automatic note_fail(input string msg);
    $display("test %s: %s", cur_test, msg);
    test_errs++;
    errors++;
  endtask

  task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("Error %s %s: expected %0h, actual %0h", cur_test, what, exp, act);
      test_errs++;
      errors++;
    end
  endtask

  // outputs settle after the edge, sample mid-cycle
  always @(negedge clk) begin
    if (due_q.size() != 0 && due_q[0] < cyc) begin
      note_fail("an expected output cycle was never compared");
      void'(due_q.pop_front());
      void'(exp_q.pop_front());
    end else if (due_q.size() != 0 && due_q[0] == cyc) begin
      cur = exp_q.pop_front();
      void'(due_q.pop_front());
      compare("de", 32'(cur.de), 32'(de));
      compare("hsync", 32'(cur.hs), 32'(hsync));
      compare("vsync", 32'(cur.vs), 32'(vsync));
      if (cur.de) begin
        compare("out_data", 32'(cur.data), 32'(out_data));
        compare("hcount", 32'(cur.hc), 32'(hcount));
        compare("vcount", 32'(cur.vc), 32'(vcount));
      end
    end
    // read data is valid once ack rises
    if (cfg_ack && !ack_seen && !cfg_we) begin
      if (rd_q.size() == 0) begin
        note_fail("read acknowledged with no read pending");
      end else begin
        compare("cfg_rdata", 32'(rd_q.pop_front()), 32'(cfg_rdata));
      end
    end
    ack_seen = cfg_ack;
  end

endmodule

// File: source/video_rx_top.sv
`timescale 1ns/1ns

module video_rx_top
  import vid_timing_pkg::*;
#(
  parameter int PIX_W = 24
) (
  input  logic             clk,
  input  logic             reset,

  // packetized pixel stream
  input  logic             pix_valid,
  input  logic [PIX_W-1:0] pix_data,

  // recovered raster
  output logic [PIX_W-1:0] out_data,
  output logic             de,
  output logic             hsync,
  output logic             vsync,
  output pix_cnt_t         hcount,
  output line_cnt_t        vcount,

  // host register port
  input  logic             cfg_req,
  input  logic             cfg_we,
  input  reg_addr_t        cfg_addr,
  input  reg_data_t        cfg_wdata,
  output logic             cfg_ack,
  output reg_data_t        cfg_rdata
);

  gap_timing_if tim_if ();

  timing_cfg_regs u_regs (
    .clk       (clk),
    .reset     (reset),
    .cfg_req   (cfg_req),
    .cfg_we    (cfg_we),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cfg_ack   (cfg_ack),
    .cfg_rdata (cfg_rdata),
    .tim       (tim_if)
  );

  sync_recover #(
    .PIX_W (PIX_W)
  ) u_recover (
    .clk       (clk),
    .reset     (reset),
    .pix_valid (pix_valid),
    .pix_data  (pix_data),
    .out_data  (out_data),
    .de        (de),
    .hsync     (hsync),
    .vsync     (vsync),
    .hcount    (hcount),
    .vcount    (vcount),
    .tim       (tim_if)
  );

endmodule

// File: source/sync_recover.sv
`timescale 1ns/1ns

module sync_recover
  import vid_timing_pkg::*;
#(
  parameter int PIX_W = 24
) (
  input  logic             clk,
  input  logic             reset,

  input  logic             pix_valid,
  input  logic [PIX_W-1:0] pix_data,

  output logic [PIX_W-1:0] out_data,
  output logic             de,
  output logic             hsync,
  output logic             vsync,
  output pix_cnt_t         hcount,
  output line_cnt_t        vcount,

  gap_timing_if.recover    tim
);

  gap_cnt_t   idle_cnt;
  gap_cnt_t   idle_run;
  gap_state_t state;
  gap_state_t state_nxt;
  logic       line_evt;
  logic       frame_evt;

  pix_cnt_t   pix_cnt;
  line_cnt_t  line_cnt;
  sync_len_t  hs_cnt;
  logic       vs_hold;

  // first pipeline stage
  logic [PIX_W-1:0] d1_data;
  logic             d1_de;
  pix_cnt_t         d1_hcount;
  line_cnt_t        d1_vcount;

  // idle run including the current cycle, saturating
  always_comb begin
    if (pix_valid) begin
      idle_run = '0;
    end else if (idle_cnt == '1) begin
      idle_run = idle_cnt;
    end else begin
      idle_run = idle_cnt + 1'b1;
    end
  end

  // the state gate makes each event fire once per gap,
  // even when the run saturates on the threshold
  assign line_evt  = !pix_valid && (idle_run == tim.hgap_min) &&
                     (state == ACTIVE || state == SHORT_GAP);
  assign frame_evt = !pix_valid && (idle_run == tim.vgap_min) &&
                     (state == LINE_GAP);

  always_comb begin
    state_nxt = state;
    if (pix_valid) begin
      state_nxt = ACTIVE;
    end else if (frame_evt) begin
      state_nxt = FRAME_GAP;
    end else if (line_evt) begin
      state_nxt = LINE_GAP;
    end else if (state == ACTIVE) begin
      state_nxt = SHORT_GAP;
    end
  end

  // gap classifier
  always_ff @(posedge clk) begin
    if (reset) begin
      idle_cnt <= '0;
      // no events until the first pixel after reset
      state    <= FRAME_GAP;
    end else begin
      idle_cnt <= idle_run;
      state    <= state_nxt;
    end
  end

  // counters, status captures and raw sync state
  always_ff @(posedge clk) begin
    if (reset) begin
      pix_cnt         <= '0;
      line_cnt        <= '0;
      hs_cnt          <= '0;
      vs_hold         <= 1'b0;
      tim.line_len    <= '0;
      tim.frame_lines <= '0;
    end else begin
      if (line_evt) begin
        pix_cnt <= '0;
      end else if (pix_valid) begin
        pix_cnt <= pix_cnt + 1'b1;
      end

      if (frame_evt) begin
        line_cnt <= '0;
      end else if (line_evt) begin
        line_cnt <= line_cnt + 1'b1;
      end

      if (line_evt && pix_cnt != '0) begin
        tim.line_len <= pix_cnt;
      end
      if (frame_evt) begin
        tim.frame_lines <= line_cnt;
      end

      // hsync runs its full length, pixels or not
      if (line_evt) begin
        hs_cnt <= tim.hsync_len;
      end else if (hs_cnt != '0) begin
        hs_cnt <= hs_cnt - 1'b1;
      end

      // vsync holds through the frame gap until the next pixel
      if (frame_evt) begin
        vs_hold <= 1'b1;
      end else if (pix_valid) begin
        vs_hold <= 1'b0;
      end
    end
  end

  // stage 1, counts before this cycle's update
  always_ff @(posedge clk) begin
    if (reset) begin
      d1_de     <= 1'b0;
      d1_hcount <= '0;
      d1_vcount <= '0;
    end else begin
      d1_de     <= pix_valid;
      d1_hcount <= pix_cnt;
      d1_vcount <= line_cnt;
    end
  end

  always_ff @(posedge clk) begin
    d1_data  <= pix_data;
    out_data <= d1_data;
  end

  // stage 2, polarity applied here
  always_ff @(posedge clk) begin
    if (reset) begin
      de     <= 1'b0;
      hcount <= '0;
      vcount <= '0;
      hsync  <= 1'b0;
      vsync  <= 1'b0;
    end else begin
      de     <= d1_de;
      hcount <= d1_hcount;
      vcount <= d1_vcount;
      hsync  <= (hs_cnt != '0) ^ tim.polarity;
      vsync  <= vs_hold ^ tim.polarity;
    end
  end

endmodule

// File: source/timing_cfg_regs.sv
`timescale 1ns/1ns

module timing_cfg_regs
  import vid_timing_pkg::*;
(
  input  logic      clk,
  input  logic      reset,

  input  logic      cfg_req,
  input  logic      cfg_we,
  input  reg_addr_t cfg_addr,
  input  reg_data_t cfg_wdata,
  output logic      cfg_ack,
  output reg_data_t cfg_rdata,

  gap_timing_if.regs tim
);

  typedef enum logic {
    HS_IDLE,
    HS_ACK
  } hs_state_t;

  hs_state_t hs_state;
  logic      access;
  reg_data_t rd_mux;

  // access happens once, on the first sampled req
  assign access  = cfg_req && (hs_state == HS_IDLE);
  assign cfg_ack = (hs_state == HS_ACK);

  // four-phase handshake
  always_ff @(posedge clk) begin
    if (reset) begin
      hs_state <= HS_IDLE;
    end else begin
      case (hs_state)
        HS_IDLE: begin
          if (cfg_req) begin
            hs_state <= HS_ACK;
          end
        end
        HS_ACK: begin
          // hold ack until the host lets go of req
          if (!cfg_req) begin
            hs_state <= HS_IDLE;
          end
        end
        default: hs_state <= HS_IDLE;
      endcase
    end
  end

  // configuration registers
  always_ff @(posedge clk) begin
    if (reset) begin
      tim.hgap_min  <= DEF_HGAP_MIN;
      tim.vgap_min  <= DEF_VGAP_MIN;
      tim.hsync_len <= DEF_HSYNC_LEN;
      tim.polarity  <= DEF_POLARITY;
    end else if (access && cfg_we) begin
      case (cfg_addr)
        ADDR_HGAP_MIN:  tim.hgap_min  <= cfg_wdata;
        ADDR_VGAP_MIN:  tim.vgap_min  <= cfg_wdata;
        ADDR_HSYNC_LEN: tim.hsync_len <= sync_len_t'(cfg_wdata);
        ADDR_POLARITY:  tim.polarity  <= cfg_wdata[0];
        // status and unused addresses drop the write
        default: ;
      endcase
    end
  end

  // read mux, status comes straight from the recovery side
  always_comb begin
    case (cfg_addr)
      ADDR_HGAP_MIN:    rd_mux = tim.hgap_min;
      ADDR_VGAP_MIN:    rd_mux = tim.vgap_min;
      ADDR_HSYNC_LEN:   rd_mux = reg_data_t'(tim.hsync_len);
      ADDR_POLARITY:    rd_mux = reg_data_t'(tim.polarity);
      ADDR_LINE_LEN:    rd_mux = reg_data_t'(tim.line_len);
      ADDR_FRAME_LINES: rd_mux = reg_data_t'(tim.frame_lines);
      default:          rd_mux = '0;
    endcase
  end

  // captured with the access, stable while ack is high
  always_ff @(posedge clk) begin
    if (access) begin
      cfg_rdata <= rd_mux;
    end
  end

endmodule

// File: source/gap_timing_if.sv
`timescale 1ns/1ns

interface gap_timing_if
  import vid_timing_pkg::*;
();

  // configuration, written by the register block
  gap_cnt_t  hgap_min;
  gap_cnt_t  vgap_min;
  sync_len_t hsync_len;
  logic      polarity;

  // measured status, from the recovery block
  pix_cnt_t  line_len;
  line_cnt_t frame_lines;

  modport regs (
    output hgap_min, vgap_min, hsync_len, polarity,
    input  line_len, frame_lines
  );

  modport recover (
    input  hgap_min, vgap_min, hsync_len, polarity,
    output line_len, frame_lines
  );

endinterface

// File: source/vid_timing_pkg.sv
package vid_timing_pkg;

  // idle run length and gap thresholds
  typedef logic [15:0] gap_cnt_t;
  // pixel index within a line, line length
  typedef logic [10:0] pix_cnt_t;
  // line index within a frame, frame height
  typedef logic [10:0] line_cnt_t;
  typedef logic [7:0]  sync_len_t;
  typedef logic [2:0]  reg_addr_t;
  typedef logic [15:0] reg_data_t;

  // register map
  localparam reg_addr_t ADDR_HGAP_MIN    = 3'd0;
  localparam reg_addr_t ADDR_VGAP_MIN    = 3'd1;
  localparam reg_addr_t ADDR_HSYNC_LEN   = 3'd2;
  localparam reg_addr_t ADDR_POLARITY    = 3'd3;
  localparam reg_addr_t ADDR_LINE_LEN    = 3'd4;
  localparam reg_addr_t ADDR_FRAME_LINES = 3'd5;

  // configuration after reset
  localparam gap_cnt_t  DEF_HGAP_MIN  = 16'd16;
  localparam gap_cnt_t  DEF_VGAP_MIN  = 16'd200;
  localparam sync_len_t DEF_HSYNC_LEN = 8'd8;
  localparam logic      DEF_POLARITY  = 1'b0;

  // classification of the current input run
  typedef enum logic [1:0] {
    ACTIVE,
    SHORT_GAP,
    LINE_GAP,
    FRAME_GAP
  } gap_state_t;

endpackage
